// File: Makefile
VERILATOR ?= verilator
TOP       ?= mips_core_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
verilog/mips_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/mips_core.sv
verification/mips_core_assert.sv
verification/mips_core_tb.sv

// File: verification/mips_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core_assert import mips_pkg::*; (
	input wire              clk,
	input wire              arst_n,
	input wire imem_write_t imem_load,
	input wire wb_result_t  wb,
	input wire              stall
);

	// r0 writes never reach the trace
	rd_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
		wb.valid |-> (wb.rd != '0))
		else $error("writeback valid with rd 0");

	load_in_reset: assert property (@(posedge clk)
		imem_load.we |-> !arst_n)
		else $error("program load while out of reset");

	// load-use gives one cycle, branch after a writer at most two
	stall_bounded: assert property (@(posedge clk) disable iff (!arst_n)
		(stall && $past(stall)) |=> !stall)
		else $error("stall held for more than 2 cycles");

	quiet_after_reset: assert property (@(posedge clk)
		$rose(arst_n) |-> !wb.valid)
		else $error("writeback valid in the first cycle after reset");

endmodule

bind mips_core mips_core_assert u_assert (
	.clk(clk),
	.arst_n(arst_n),
	.imem_load(imem_load),
	.wb(wb),
	.stall(stall)
);

`default_nettype wire

// File: verification/mips_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core_tb import mips_pkg::*; ();

	localparam string tests_file       = "verification/mips_tests.txt";
	localparam int    quiet_cycles     = 10;
	localparam int    min_reset_cycles = 8;

	logic        clk;
	logic        arst_n;
	imem_write_t imem_load;
	wb_result_t  wb;

	// test data in flat queues indexed through per-test start and length
	string     names[$];
	word_t     prog_words[$];
	int        prog_start[$];
	int        prog_len[$];
	reg_addr_t exp_rd[$];
	word_t     exp_data[$];
	int        exp_start[$];
	int        exp_len[$];

	string cur_name;
	int    cur_start;
	int    cur_len;
	int    seen;
	logic  checking;
	int    errors;
	int    cycles;
	int    cycle_limit;

	mips_core #(
		.IMEM_ADDR_W(8),
		.DMEM_ADDR_W(8)
	) DUT (
		.clk(clk),
		.arst_n(arst_n),
		.imem_load(imem_load),
		.wb(wb)
	);

	always #5 clk = ~clk;

	task automatic check_reg(reg_addr_t expected, reg_addr_t actual);
		if (actual !== expected) begin
			$display("Fail %s: writeback %0d expected rd %0d, actual rd %0d",
				cur_name, seen, expected, actual);
			errors++;
		end
	endtask

	task automatic check_data(word_t expected, word_t actual);
		if (actual !== expected) begin
			$display("Fail %s: writeback %0d expected data %h, actual data %h",
				cur_name, seen, expected, actual);
			errors++;
		end
	endtask

	task automatic read_tests(output bit ok);
		int               fd;
		int               code;
		int               bad;
		int               n_words;
		int               n_wb;
		int               rd;
		word_t            value;
		logic [8*32-1:0]  tok;
		logic [8*256-1:0] line;
		string            word;
		bad = 0;
		fd  = $fopen(tests_file, "r");
		if (fd != 0) begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				word = string'(tok);
				if (word != "test") begin
					// comment line
					code = $fgets(line, fd);
				end else begin
					code = $fscanf(fd, "%s %d %d", tok, n_words, n_wb);
					if (code != 3) begin
						bad++;
						break;
					end
					names.push_back(string'(tok));
					prog_start.push_back(prog_words.size());
					prog_len.push_back(n_words);
					exp_start.push_back(exp_rd.size());
					exp_len.push_back(n_wb);
					for (int i = 0; i < n_words; i++) begin
						code = $fscanf(fd, "%h", value);
						if (code != 1) begin
							bad++;
						end
						prog_words.push_back(value);
					end
					for (int i = 0; i < n_wb; i++) begin
						code = $fscanf(fd, "%d %h", rd, value);
						if (code != 2) begin
							bad++;
						end
						exp_rd.push_back(reg_addr_t'(rd));
						exp_data.push_back(value);
					end
				end
			end
			$fclose(fd);
		end
		ok = (fd != 0) && (names.size() > 0) && (bad == 0);
	endtask

	// program load happens while the core is held in reset
	task automatic run_test(int t);
		int hold;
		cur_name  = names[t];
		cur_start = exp_start[t];
		cur_len   = exp_len[t];
		seen      = 0;
		hold      = (prog_len[t] > min_reset_cycles) ? prog_len[t] : min_reset_cycles;
		@(posedge clk);
		arst_n <= 1'b0;
		for (int i = 0; i < hold; i++) begin
			if (i < prog_len[t]) begin
				imem_load <= '{we: 1'b1, addr: 16'(i), data: prog_words[prog_start[t] + i]};
			end else begin
				imem_load <= '0;
			end
			@(posedge clk);
		end
		arst_n    <= 1'b1;
		imem_load <= '0;
		checking  = 1'b1;
		while (seen < cur_len) begin
			@(posedge clk);
		end
		repeat (quiet_cycles) @(posedge clk);
		checking = 1'b0;
	endtask

	// trace monitor sampled mid cycle
	always @(negedge clk) begin
		if (checking && wb.valid) begin
			if (seen < cur_len) begin
				check_reg(exp_rd[cur_start + seen], wb.rd);
				check_data(exp_data[cur_start + seen], wb.data);
			end else begin
				$display("unexpected extra writeback to r%0d with data %h in test %s",
					wb.rd, wb.data, cur_name);
				errors++;
			end
			seen++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: test %s did not finish within %0d cycles", cur_name, cycle_limit);
			$display("%0d errors before the timeout", errors);
			$display("tests failed");
			$finish;
		end
	end

	initial begin
		bit ok;
		clk         = 1'b0;
		arst_n      = 1'b0;
		imem_load   = '0;
		checking    = 1'b0;
		errors      = 0;
		cycles      = 0;
		cycle_limit = 0;
		seen        = 0;
		cur_name    = "none";
		read_tests(ok);
		if (ok) begin
			// 8 cycles per program word and 20 per test
			cycle_limit = 8 * prog_words.size() + 20 * names.size();
			for (int t = 0; t < names.size(); t++) begin
				run_test(t);
			end
		end else begin
			$display("could not read the tests from %s", tests_file);
			errors++;
		end
		$display("%0d tests run, %0d errors", names.size(), errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/mips_tests.txt
# each test: test <name> <instruction count> <writeback count>
# then the instruction words in hex, then writebacks as <rd decimal> <data hex>
test alu_ops 17 16
20080005 2009fffd 01095020 01095822 01096024 01096825
01097026 01097827 0128802a 0128882b 00099100 00099f02
0009a043 3135ff00 34168001 2937fffe 1000ffff
8 00000005  9 fffffffd  10 00000002  11 00000008
12 00000005  13 fffffffd  14 fffffff8  15 00000002
16 00000001  17 00000000  18 ffffffd0  19 0000000f
20 fffffffe  21 0000ff00  22 00008001  23 00000001

test load_store 10 7
20081234 2009000c ad280004 8c0a0010 014a5820
8d2c0004 ac0c0000 8c0d0000 01a87022 1000ffff
8 00001234  9 0000000c  10 00001234  11 00002468
12 00001234  13 00001234  14 00000000

test branches 12 5
20080007 20090007 11090001 200a0001 15090001 200b0002
210c0001 15880001 200d0003 11880001 200e0004 1000ffff
8 00000007  9 00000007  11 00000002  12 00000008  14 00000004

test r0_writes 6 3
20000005 00004020 20000009 20090001 00095025 1000ffff
8 00000000  9 00000001  10 00000001

test counted_loop 7 9
20080003 20090000 01284820 2108ffff 1500fffd 212a0064 1000ffff
8 00000003  9 00000000  9 00000003  8 00000002  9 00000005
8 00000001  9 00000006  8 00000000  10 0000006a

// File: verilog/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import mips_pkg::*; (
	input  wire             clk,
	input  wire             arst_n,
	input  wire if_id_t     if_id,
	input  wire reg_addr_t  ex_dest,
	input  wire             ex_reg_write,
	input  wire             ex_mem_read,
	input  wire reg_addr_t  mem_dest,
	input  wire             mem_reg_write,
	input  wire wb_result_t wb,
	output logic            stall,
	output logic            branch_taken,
	output word_t           branch_target,
	output id_ex_t          id_ex
);

	word_t     regs [32];
	instr_t    instr;
	ctrl_t     ctrl;
	alu_op_e   alu_op;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t dest;
	word_t     rs_val;
	word_t     rt_val;
	word_t     imm_ext;
	logic      uses_rs;
	logic      uses_rt;
	logic      ex_hit;
	logic      mem_hit;
	logic      operands_equal;

	// register read with write-through from writeback, r0 reads as zero
	function automatic word_t read_reg(reg_addr_t addr);
		if (addr == '0) begin
			return '0;
		end else if (wb.valid && wb.rd == addr) begin
			return wb.data;
		end
		return regs[addr];
	endfunction

	assign instr = if_id.instr;
	assign rs    = instr.r.rs;
	assign rt    = instr.i.rt;
	assign dest  = (instr.r.opcode == op_rtype) ? instr.r.rd : instr.i.rt;

	// main controller
	always_comb begin
		ctrl    = '0;
		alu_op  = alu_add;
		uses_rs = 1'b1;
		uses_rt = 1'b0;
		case (instr.r.opcode)
			op_rtype: begin
				ctrl.reg_write = 1'b1;
				uses_rt        = 1'b1;
				case (instr.r.funct)
					fn_add:  alu_op = alu_add;
					fn_sub:  alu_op = alu_sub;
					fn_and:  alu_op = alu_and;
					fn_or:   alu_op = alu_or;
					fn_xor:  alu_op = alu_xor;
					fn_nor:  alu_op = alu_nor;
					fn_slt:  alu_op = alu_slt;
					fn_sltu: alu_op = alu_sltu;
					fn_sll:  alu_op = alu_sll;
					fn_srl:  alu_op = alu_srl;
					fn_sra:  alu_op = alu_sra;
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			op_addi: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
			end
			op_slti: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				alu_op         = alu_slt;
			end
			op_andi: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.zero_ext  = 1'b1;
				alu_op         = alu_and;
			end
			op_ori: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.zero_ext  = 1'b1;
				alu_op         = alu_or;
			end
			op_lw: begin
				ctrl.reg_write  = 1'b1;
				ctrl.mem_read   = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.alu_src    = 1'b1;
			end
			op_sw: begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				uses_rt        = 1'b1;
			end
			op_beq: begin
				ctrl.branch = 1'b1;
				uses_rt     = 1'b1;
			end
			op_bne: begin
				ctrl.branch    = 1'b1;
				ctrl.branch_ne = 1'b1;
				uses_rt        = 1'b1;
			end
			// anything else passes through as a no-op
			default: uses_rs = 1'b0;
		endcase
	end

	always_comb begin
		rs_val = read_reg(rs);
		rt_val = read_reg(rt);
	end

	always_ff @(posedge clk) begin
		if (wb.valid) begin
			regs[wb.rd] <= wb.data;
		end
	end

	assign imm_ext = ctrl.zero_ext ? {16'h0000, instr.i.imm} : {{16{instr.i.imm[15]}}, instr.i.imm};

	// hazard detection
	always_comb begin
		ex_hit  = (ex_dest != '0) && ((uses_rs && ex_dest == rs) || (uses_rt && ex_dest == rt));
		mem_hit = (mem_dest != '0) && ((uses_rs && mem_dest == rs) || (uses_rt && mem_dest == rt));
		stall   = (ex_mem_read && ex_hit) ||
			(ctrl.branch && ((ex_reg_write && ex_hit) || (mem_reg_write && mem_hit)));
	end

	// beq takes on equal, bne on not equal
	assign operands_equal = (rs_val == rt_val);
	assign branch_taken   = ctrl.branch && !stall && (operands_equal != ctrl.branch_ne);
	assign branch_target  = if_id.pc_plus4 + {imm_ext[xlen-3:0], 2'b00};

	// ID/EX register, bubble while stalled
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_ex <= '0;
		end else if (stall) begin
			id_ex <= '0;
		end else begin
			id_ex.ctrl   <= ctrl;
			id_ex.alu_op <= alu_op;
			id_ex.shamt  <= instr.r.shamt;
			id_ex.rs     <= rs;
			id_ex.rt     <= rt;
			id_ex.dest   <= dest;
			id_ex.op_a   <= rs_val;
			id_ex.op_b   <= rt_val;
			id_ex.imm    <= imm_ext;
		end
	end

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import mips_pkg::*; (
	input  wire             clk,
	input  wire             arst_n,
	input  wire id_ex_t     id_ex,
	input  wire wb_result_t wb,
	output reg_addr_t       ex_dest,
	output logic            ex_reg_write,
	output logic            ex_mem_read,
	output ex_mem_t         ex_mem
);

	fwd_sel_e fwd_a;
	fwd_sel_e fwd_b;
	word_t    a_val;
	word_t    b_fwd;
	word_t    b_val;
	word_t    result;

	// forwarding unit
	// a load in EX/MEM has no data yet so only non-loads forward from there
	function automatic fwd_sel_e pick_source(reg_addr_t src, ex_mem_t mem, wb_result_t w);
		if (mem.reg_write && !mem.mem_read && mem.dest != '0 && mem.dest == src) begin
			return fwd_mem;
		end else if (w.valid && w.rd == src) begin
			return fwd_wb;
		end
		return fwd_rf;
	endfunction

	function automatic word_t select_operand(fwd_sel_e sel, word_t rf_val, word_t mem_val,
			word_t wb_val);
		case (sel)
			fwd_mem: return mem_val;
			fwd_wb:  return wb_val;
			default: return rf_val;
		endcase
	endfunction

	assign fwd_a = pick_source(id_ex.rs, ex_mem, wb);
	assign fwd_b = pick_source(id_ex.rt, ex_mem, wb);

	assign a_val = select_operand(fwd_a, id_ex.op_a, ex_mem.alu_result, wb.data);
	assign b_fwd = select_operand(fwd_b, id_ex.op_b, ex_mem.alu_result, wb.data);

	// immediate or register for the second input
	assign b_val = id_ex.ctrl.alu_src ? id_ex.imm : b_fwd;

	// shifts operate on rt by shamt
	always_comb begin
		case (id_ex.alu_op)
			alu_add:  result = a_val + b_val;
			alu_sub:  result = a_val - b_val;
			alu_and:  result = a_val & b_val;
			alu_or:   result = a_val | b_val;
			alu_xor:  result = a_val ^ b_val;
			alu_nor:  result = ~(a_val | b_val);
			alu_slt:  result = {{(xlen-1){1'b0}}, $signed(a_val) < $signed(b_val)};
			alu_sltu: result = {{(xlen-1){1'b0}}, a_val < b_val};
			alu_sll:  result = b_val << id_ex.shamt;
			alu_srl:  result = b_val >> id_ex.shamt;
			alu_sra:  result = $signed(b_val) >>> id_ex.shamt;
			default:  result = a_val + b_val;
		endcase
	end

	// seen by the hazard check in decode
	assign ex_dest      = id_ex.dest;
	assign ex_reg_write = id_ex.ctrl.reg_write;
	assign ex_mem_read  = id_ex.ctrl.mem_read;

	// EX/MEM register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem <= '0;
		end else begin
			ex_mem.reg_write  <= id_ex.ctrl.reg_write;
			ex_mem.mem_read   <= id_ex.ctrl.mem_read;
			ex_mem.mem_write  <= id_ex.ctrl.mem_write;
			ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
			ex_mem.dest       <= id_ex.dest;
			ex_mem.alu_result <= result;
			ex_mem.store_data <= b_fwd;
		end
	end

endmodule

`default_nettype wire

// File: verilog/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import mips_pkg::*; #(
	parameter int IMEM_ADDR_W = 8
) (
	input  wire              clk,
	input  wire              arst_n,
	input  wire imem_write_t imem_load,
	input  wire              stall,
	input  wire              branch_taken,
	input  wire word_t       branch_target,
	output if_id_t           if_id
);

	// program memory, one word per entry
	word_t imem [2**IMEM_ADDR_W];

	word_t pc;
	word_t pc_plus4;
	word_t fetched;

	assign pc_plus4 = pc + 32'd4;

	// word address of the pc, low bits only
	assign fetched = imem[pc[IMEM_ADDR_W+1:2]];

	// load port is only driven while the core sits in reset
	always_ff @(posedge clk) begin
		if (imem_load.we) begin
			imem[imem_load.addr[IMEM_ADDR_W-1:0]] <= imem_load.data;
		end
	end

	// program counter
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (branch_taken) begin
			pc <= branch_target;
		end else if (!stall) begin
			pc <= pc_plus4;
		end
	end

	// IF/ID register
	// a taken branch squashes the word fetched behind it
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			if_id <= '0;
		end else if (branch_taken) begin
			if_id.pc_plus4 <= pc_plus4;
			if_id.instr    <= '0;
		end else if (!stall) begin
			if_id.pc_plus4 <= pc_plus4;
			if_id.instr    <= fetched;
		end
	end

endmodule

`default_nettype wire

// File: verilog/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage import mips_pkg::*; #(
	parameter int DMEM_ADDR_W = 8
) (
	input  wire          clk,
	input  wire          arst_n,
	input  wire ex_mem_t ex_mem,
	output reg_addr_t    mem_dest,
	output logic         mem_reg_write,
	output wb_result_t   wb
);

	word_t                  dmem [2**DMEM_ADDR_W];
	logic [DMEM_ADDR_W-1:0] addr;
	word_t                  load_data;

	// word addressed, byte offset dropped
	assign addr      = ex_mem.alu_result[DMEM_ADDR_W+1:2];
	assign load_data = dmem[addr];

	always_ff @(posedge clk) begin
		if (ex_mem.mem_write) begin
			dmem[addr] <= ex_mem.store_data;
		end
	end

	// for the branch hazard check in decode
	assign mem_dest      = ex_mem.dest;
	assign mem_reg_write = ex_mem.reg_write;

	// MEM/WB register, writes to r0 stay invisible
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb <= '0;
		end else begin
			wb.valid <= ex_mem.reg_write && (ex_mem.dest != '0);
			wb.rd    <= ex_mem.dest;
			wb.data  <= ex_mem.mem_to_reg ? load_data : ex_mem.alu_result;
		end
	end

endmodule

`default_nettype wire

// File: verilog/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core import mips_pkg::*; #(
	parameter int IMEM_ADDR_W = 8,
	parameter int DMEM_ADDR_W = 8
) (
	input  wire              clk,
	input  wire              arst_n,
	input  wire imem_write_t imem_load,
	output wb_result_t       wb
);

	if_id_t    if_id;
	logic      stall;
	logic      branch_taken;
	word_t     branch_target;
	id_ex_t    id_ex;
	reg_addr_t ex_dest;
	logic      ex_reg_write;
	logic      ex_mem_read;
	ex_mem_t   ex_mem;
	reg_addr_t mem_dest;
	logic      mem_reg_write;

	fetch_stage #(
		.IMEM_ADDR_W(IMEM_ADDR_W)
	) u_fetch (
		.clk(clk),
		.arst_n(arst_n),
		.imem_load(imem_load),
		.stall(stall),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.if_id(if_id)
	);

	decode_stage u_decode (
		.clk(clk),
		.arst_n(arst_n),
		.if_id(if_id),
		.ex_dest(ex_dest),
		.ex_reg_write(ex_reg_write),
		.ex_mem_read(ex_mem_read),
		.mem_dest(mem_dest),
		.mem_reg_write(mem_reg_write),
		.wb(wb),
		.stall(stall),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.id_ex(id_ex)
	);

	execute_stage u_execute (
		.clk(clk),
		.arst_n(arst_n),
		.id_ex(id_ex),
		.wb(wb),
		.ex_dest(ex_dest),
		.ex_reg_write(ex_reg_write),
		.ex_mem_read(ex_mem_read),
		.ex_mem(ex_mem)
	);

	memory_stage #(
		.DMEM_ADDR_W(DMEM_ADDR_W)
	) u_memory (
		.clk(clk),
		.arst_n(arst_n),
		.ex_mem(ex_mem),
		.mem_dest(mem_dest),
		.mem_reg_write(mem_reg_write),
		.wb(wb)
	);

endmodule

`default_nettype wire

// File: verilog/mips_pkg.sv
`default_nettype none

package mips_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0]      reg_addr_t;

	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_beq   = 6'h04,
		op_bne   = 6'h05,
		op_addi  = 6'h08,
		op_slti  = 6'h0a,
		op_andi  = 6'h0c,
		op_ori   = 6'h0d,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		fn_sll  = 6'h00,
		fn_srl  = 6'h02,
		fn_sra  = 6'h03,
		fn_add  = 6'h20,
		fn_sub  = 6'h22,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_xor  = 6'h26,
		fn_nor  = 6'h27,
		fn_slt  = 6'h2a,
		fn_sltu = 6'h2b
	} funct_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_nor,
		alu_slt,
		alu_sltu,
		alu_sll,
		alu_srl,
		alu_sra
	} alu_op_e;

	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm;
	} i_fields_t;

	// one instruction word seen as R-type or I-type
	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} instr_t;

	typedef struct packed {
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic mem_to_reg;
		logic alu_src;
		logic zero_ext;
		logic branch;
		logic branch_ne;
	} ctrl_t;

	typedef enum logic [1:0] {
		fwd_rf  = 2'd0,
		fwd_mem = 2'd1,
		fwd_wb  = 2'd2
	} fwd_sel_e;

	typedef struct packed {
		word_t  pc_plus4;
		instr_t instr;
	} if_id_t;

	typedef struct packed {
		ctrl_t      ctrl;
		alu_op_e    alu_op;
		logic [4:0] shamt;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  dest;
		word_t      op_a;
		word_t      op_b;
		word_t      imm;
	} id_ex_t;

	typedef struct packed {
		logic      reg_write;
		logic      mem_read;
		logic      mem_write;
		logic      mem_to_reg;
		reg_addr_t dest;
		word_t     alu_result;
		word_t     store_data;
	} ex_mem_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		word_t     data;
	} wb_result_t;

	typedef struct packed {
		logic        we;
		logic [15:0] addr;
		word_t       data;
	} imem_write_t;

endpackage

`default_nettype wire
